/* addSubV.sv */
`timescale 1ns/1ps
`default_nettype none

// two's complement add/sub, S = SUB ? A-B-CI : A+B+CI
module addSubV
	import arithPkg::*;
#(
	parameter int width = opWidth,      // word width
	parameter int speed = prefixSpeed   // carry network choice
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,
	input  logic             CI,   // carry in, added or subtracted
	input  logic             SUB,  // subtract enable
	output logic [width-1:0] S,
	output logic             V     // overflow
);

	logic [width-1:0] bInv;   // B, inverted for subtraction
	logic             ciEff;  // carry actually entering bit 0
	logic [width-1:0] gIn;
	logic [width-1:0] pIn;
	logic [width-1:0] gOut;   // carry out of each bit
	logic [width-1:0] halfSum;

	// a - b = a + ~b + 1, the +1 comes from the inverted carry
	assign bInv  = B ^ {width{SUB}};
	assign ciEff = CI ^ SUB;

	// bit 0 absorbs the carry-in as a full adder majority
	assign gIn[0]     = (A[0] & bInv[0]) | (A[0] & ciEff) | (bInv[0] & ciEff);
	assign pIn[0]     = 1'b0;
	assign halfSum[0] = A[0] ^ bInv[0];

	for (genvar i = 1; i < width; i++) begin : bitPre
		assign gIn[i]     = A[i] & bInv[i];
		assign pIn[i]     = A[i] | bInv[i];
		assign halfSum[i] = ~gIn[i] & pIn[i];  // xor from and/or
	end

	// group propagate not needed, carry-in already lives in the generate
	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix_i (
		.GI(gIn),
		.PI(pIn),
		.GO(gOut),
		.PO()
	);

	assign S = halfSum ^ {gOut[width-2:0], ciEff};  // carry into each bit
	assign V = gOut[width-1] ^ gOut[width-2];       // carry in vs out of msb

endmodule

`default_nettype wire

/* arithExec.sv */
`timescale 1ns/1ps
`default_nettype none

// runs one operation per launch, result two edges later
module arithExec
	import arithPkg::*;
(
	input  logic         clk,
	input  logic         rstN,
	input  logic         launch,  // one-cycle start strobe
	input  arithCmd_t    cmd,
	output arithResult_t result
);

	arithCmd_t          cmdQ;  // operands held for the adder
	logic               busy;  // launch seen, sum not yet stored
	logic               sub;
	logic               ci;
	logic [opWidth-1:0] sum;
	logic               ovf;
	logic [opWidth-1:0] sumQ;
	logic               ovfQ;
	logic               doneQ;

	always_ff @(posedge clk) begin
		if (launch)
			cmdQ <= cmd;
	end

	// opcode to adder controls
	always_comb begin
		case (cmdQ.op)
			opAdd:   begin sub = 1'b0; ci = 1'b0; end
			opSub:   begin sub = 1'b1; ci = 1'b0; end
			opAddCi: begin sub = 1'b0; ci = 1'b1; end
			opSubCi: begin sub = 1'b1; ci = 1'b1; end
			default: begin sub = 1'b0; ci = 1'b0; end
		endcase
	end

	addSubV #(
		.width(opWidth),
		.speed(prefixSpeed)
	) addSub_i (
		.A(cmdQ.a),
		.B(cmdQ.b),
		.CI(ci),
		.SUB(sub),
		.S(sum),
		.V(ovf)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy  <= 1'b0;
			doneQ <= 1'b0;
			sumQ  <= '0;
			ovfQ  <= 1'b0;
		end else if (launch) begin
			busy  <= 1'b1;
			doneQ <= 1'b0;  // software sees not-done right away
		end else if (busy) begin
			busy  <= 1'b0;
			doneQ <= 1'b1;
			sumQ  <= sum;
			ovfQ  <= ovf;
		end
	end

	assign result = '{sum: sumQ, ovf: ovfQ, done: doneQ};

endmodule

`default_nettype wire

/* arithPkg.sv */
`default_nettype none

package arithPkg;

	// datapath
	localparam int opWidth     = 16;
	localparam int prefixSpeed = 2;  // network choice (serial 0, brent-kung 1, sklansky 2)

	// opcode as written into regCtrl[1:0]
	typedef enum logic [1:0] {
		opAdd   = 2'b00,  // a + b
		opSub   = 2'b01,  // a - b
		opAddCi = 2'b10,  // a + b + 1
		opSubCi = 2'b11   // a - b - 1
	} arithOp_e;

	// register map, byte offsets
	localparam logic [axiLitePkg::addrWidth-1:0] regA      = 'h0;
	localparam logic [axiLitePkg::addrWidth-1:0] regB      = 'h4;
	localparam logic [axiLitePkg::addrWidth-1:0] regCtrl   = 'h8;  // write starts an op
	localparam logic [axiLitePkg::addrWidth-1:0] regResult = 'hC;  // read only

	// result word layout, sum sits in the low opWidth bits
	localparam int ovfBit  = 16;
	localparam int doneBit = 31;

	// one operation as handed to the execution unit
	typedef struct packed {
		logic [opWidth-1:0] a;
		logic [opWidth-1:0] b;
		arithOp_e           op;
	} arithCmd_t;

	// registered outcome, polled by software
	typedef struct packed {
		logic [opWidth-1:0] sum;
		logic               ovf;   // two's complement overflow
		logic               done;  // low while an op is in flight
	} arithResult_t;

endpackage

`default_nettype wire

/* arithUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module arithUnitTb
	import axiLitePkg::*;
	import arithPkg::*;
();

	localparam int numRandom     = 250;
	localparam int numStalled    = 30;
	localparam int timeoutCycles = 6000;  // ~16 cycles per op, up to ~28 when stalled

	logic         clk;
	logic         rstN;
	axiReq_t      req;
	axiRsp_t      rsp;
	logic         stallOn = 1'b0;  // random b/r ready delays
	int           cycles = 0;
	arithResult_t expQ[$];         // reference side
	arithResult_t actQ[$];         // dut side
	string        nameQ[$];

	arithUnitTop dut_i (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.rsp(rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	// S = A +/- B +/- carry-in on sign-extended operands
	function automatic arithResult_t refAddSub(input logic [opWidth-1:0] a,
		input logic [opWidth-1:0] b, input arithOp_e op);
		int sa;
		int sb;
		int exact;
		arithResult_t r;
		sa = int'($signed(a));
		sb = int'($signed(b));
		case (op)
			opAdd:   exact = sa + sb;
			opSub:   exact = sa - sb;
			opAddCi: exact = sa + sb + 1;
			default: exact = sa - sb - 1;  // opSubCi
		endcase
		r.sum  = exact[opWidth-1:0];
		r.ovf  = (exact > 32767) || (exact < -32768);  // outside 16-bit signed range
		r.done = 1'b1;
		return r;
	endfunction

	task automatic checkResult(input string name, input arithResult_t exp,
		input arithResult_t act);
		if (act !== exp) begin
			$display("** Error %s: expected sum %h ovf %b done %b, actual sum %h ovf %b done %b",
				name, exp.sum, exp.ovf, exp.done, act.sum, act.ovf, act.done);
			$display("test failed");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic checkResp(input string name, input axiResp_e exp, input axiResp_e act);
		if (act !== exp) begin
			$display("** Error %s: expected %s, actual %s", name, exp.name(), act.name());
			$display("test failed");
			$fatal(1, "response mismatch");
		end
	endtask

	task automatic checkData(input string name, input logic [dataWidth-1:0] exp,
		input logic [dataWidth-1:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			$display("test failed");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic readyDelay();
		if (stallOn)
			repeat ($urandom_range(0, 3)) @(posedge clk);  // hold ready low a while
	endtask

	task automatic axiWrite(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data,
		output axiResp_e resp);
		@(posedge clk);
		req.awaddr  <= addr;
		req.awvalid <= 1'b1;
		req.wdata   <= data;
		req.wvalid  <= 1'b1;
		do begin
			@(negedge clk);  // sample mid cycle
		end while (!rsp.awready);
		if (!rsp.wready) begin
			$display("wready did not rise together with awready");
			$display("test failed");
			$fatal(1, "write address and data handshake split");
		end
		@(posedge clk);  // handshake edge
		req.awvalid <= 1'b0;
		req.wvalid  <= 1'b0;
		readyDelay();
		req.bready <= 1'b1;
		do begin
			@(negedge clk);
		end while (!rsp.bvalid);
		resp = rsp.bresp;
		@(posedge clk);
		req.bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [addrWidth-1:0] addr, output logic [dataWidth-1:0] data,
		output axiResp_e resp);
		@(posedge clk);
		req.araddr  <= addr;
		req.arvalid <= 1'b1;
		do begin
			@(negedge clk);
		end while (!rsp.arready);
		@(posedge clk);
		req.arvalid <= 1'b0;
		readyDelay();
		req.rready <= 1'b1;
		do begin
			@(negedge clk);
		end while (!rsp.rvalid);
		data = rsp.rdata;  // stable while rvalid waits
		resp = rsp.rresp;
		@(posedge clk);
		req.rready <= 1'b0;
	endtask

	task automatic writeOk(input string name, input logic [addrWidth-1:0] addr,
		input logic [dataWidth-1:0] data);
		axiResp_e resp;
		axiWrite(addr, data, resp);
		checkResp(name, respOkay, resp);
	endtask

	task automatic readOk(input string name, input logic [addrWidth-1:0] addr,
		output logic [dataWidth-1:0] data);
		axiResp_e resp;
		axiRead(addr, data, resp);
		checkResp(name, respOkay, resp);
	endtask

	// one full operation, result goes to the compare process
	task automatic runOp(input string name, input logic [opWidth-1:0] a,
		input logic [opWidth-1:0] b, input arithOp_e op);
		logic [dataWidth-1:0] word;
		arithResult_t got;
		writeOk(name, regA, 32'(a));
		writeOk(name, regB, 32'(b));
		writeOk(name, regCtrl, 32'(op));  // starts the op
		do begin
			readOk(name, regResult, word);
		end while (!word[doneBit]);  // poll until done
		got.sum  = word[opWidth-1:0];
		got.ovf  = word[ovfBit];
		got.done = word[doneBit];
		nameQ.push_back(name);
		expQ.push_back(refAddSub(a, b, op));
		actQ.push_back(got);
	endtask

	// compares queued results against the reference
	initial begin
		forever begin
			@(posedge clk);
			while (actQ.size() > 0)
				checkResult(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeoutCycles) begin
			$display("timeout, the tests did not finish within %0d cycles", timeoutCycles);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic [dataWidth-1:0] rnd;
		logic [dataWidth-1:0] wr;
		logic [dataWidth-1:0] rd;
		logic [dataWidth-1:0] aWord;
		logic [dataWidth-1:0] bWord;
		logic [dataWidth-1:0] snap;
		axiResp_e resp;
		void'($urandom(32'h5558));
		req  <= '0;
		rstN <= 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;

		// quiet bus and cleared result after reset
		@(negedge clk);
		checkData("reset handshake", 32'h0,
			32'({rsp.awready, rsp.wready, rsp.bvalid, rsp.arready, rsp.rvalid}));
		readOk("reset result", regResult, rd);
		checkData("reset result", 32'h0, rd);

		// overflow and carry-in corners
		runOp("add 7fff+1", 16'h7FFF, 16'h0001, opAdd);
		runOp("sub 8000-1", 16'h8000, 16'h0001, opSub);
		runOp("subci 0-0-1", 16'h0000, 16'h0000, opSubCi);
		runOp("addci ffff+ffff+1", 16'hFFFF, 16'hFFFF, opAddCi);

		for (int i = 0; i < numRandom; i++) begin
			rnd = $urandom();
			wr  = $urandom();
			runOp("random op", rnd[15:0], rnd[31:16], arithOp_e'(wr[1:0]));
		end

		// readback, upper bits of the written word are dropped
		aWord = $urandom();
		bWord = $urandom();
		wr    = $urandom();
		writeOk("readback a", regA, aWord);
		writeOk("readback b", regB, bWord);
		writeOk("readback ctrl", regCtrl, wr);
		readOk("readback a", regA, rd);
		checkData("readback a", 32'(aWord[opWidth-1:0]), rd);
		readOk("readback b", regB, rd);
		checkData("readback b", 32'(bWord[opWidth-1:0]), rd);
		readOk("readback ctrl", regCtrl, rd);
		checkData("readback ctrl", 32'(wr[1:0]), rd);

		// error responses leave the registers alone
		readOk("result snapshot", regResult, snap);
		axiWrite(regResult, 32'hFFFF_FFFF, resp);
		checkResp("write regResult", respSlvErr, resp);
		axiWrite(4'h2, 32'h1234_5678, resp);  // hole in the map
		checkResp("write unmapped", respSlvErr, resp);
		axiRead(4'h6, rd, resp);
		checkResp("read unmapped", respSlvErr, resp);
		readOk("a after errors", regA, rd);
		checkData("a after errors", 32'(aWord[opWidth-1:0]), rd);
		readOk("b after errors", regB, rd);
		checkData("b after errors", 32'(bWord[opWidth-1:0]), rd);
		readOk("ctrl after errors", regCtrl, rd);
		checkData("ctrl after errors", 32'(wr[1:0]), rd);
		readOk("result after errors", regResult, rd);
		checkData("result after errors", snap, rd);

		// same traffic with bready/rready held back
		stallOn = 1'b1;
		for (int i = 0; i < numStalled; i++) begin
			rnd = $urandom();
			wr  = $urandom();
			runOp("stalled op", rnd[15:0], rnd[31:16], arithOp_e'(wr[1:0]));
		end
		writeOk("stalled readback", regB, rnd);
		readOk("stalled readback", regB, rd);
		checkData("stalled readback", 32'(rnd[opWidth-1:0]), rd);

		while (actQ.size() > 0)
			@(posedge clk);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* arithUnitTop.sv */
`timescale 1ns/1ps
`default_nettype none

// memory-mapped adder-subtractor
module arithUnitTop
	import axiLitePkg::*;
	import arithPkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  axiReq_t req,  // axi4-lite from the processor
	output axiRsp_t rsp
);

	logic         launch;  // start strobe, regs to exec
	arithCmd_t    cmd;
	arithResult_t result;  // exec back to the read mux

	axiLiteRegs regs_i (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.rsp(rsp),
		.launch(launch),
		.cmd(cmd),
		.result(result)
	);

	// done readable two cycles after the ctrl write handshake
	arithExec exec_i (
		.clk(clk),
		.rstN(rstN),
		.launch(launch),
		.cmd(cmd),
		.result(result)
	);

endmodule

`default_nettype wire

/* arithUnit_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

// axi4-lite handshake rules at the top-level ports
module arithUnitAssertions
	import axiLitePkg::*;
(
	input logic    clk,
	input logic    rstN,
	input axiReq_t req,
	input axiRsp_t rsp
);

	// write response waits for bready
	bValidHold: assert property (@(posedge clk) disable iff (!rstN)
		rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
		else $error("bvalid or bresp changed before bready");

	rValidHold: assert property (@(posedge clk) disable iff (!rstN)
		rsp.rvalid && !req.rready |=> rsp.rvalid)
		else $error("rvalid dropped before rready");

	// read data frozen while stalled
	rDataStable: assert property (@(posedge clk) disable iff (!rstN)
		rsp.rvalid && !req.rready |=> $stable(rsp.rdata) && $stable(rsp.rresp))
		else $error("rdata or rresp changed while rvalid waited");

	quietInReset: assert property (@(posedge clk)
		!rstN |-> !(rsp.awready || rsp.wready || rsp.bvalid || rsp.arready || rsp.rvalid))
		else $error("handshake output high during reset");

endmodule

bind arithUnitTop arithUnitAssertions assert_i (
	.clk(clk),
	.rstN(rstN),
	.req(req),
	.rsp(rsp)
);

`default_nettype wire

/* axiLitePkg.sv */
`default_nettype none

package axiLitePkg;

	localparam int addrWidth = 4;  // byte address into a 16 byte window
	localparam int dataWidth = 32;

	// only the two codes this slave ever returns
	typedef enum logic [1:0] {
		respOkay   = 2'b00,
		respSlvErr = 2'b10
	} axiResp_e;

	// master side of all five channels
	typedef struct packed {
		logic [addrWidth-1:0] awaddr;
		logic                 awvalid;
		logic [dataWidth-1:0] wdata;   // no strobes, always a full word
		logic                 wvalid;
		logic                 bready;
		logic [addrWidth-1:0] araddr;
		logic                 arvalid;
		logic                 rready;
	} axiReq_t;

	// slave side of all five channels
	typedef struct packed {
		logic                 awready;
		logic                 wready;
		logic                 bvalid;
		axiResp_e             bresp;
		logic                 arready;
		logic [dataWidth-1:0] rdata;
		logic                 rvalid;
		axiResp_e             rresp;
	} axiRsp_t;

endpackage

`default_nettype wire

/* axiLiteRegs.sv */
`timescale 1ns/1ps
`default_nettype none

// axi4-lite slave holding operands and opcode
module axiLiteRegs
	import axiLitePkg::*;
	import arithPkg::*;
(
	input  logic         clk,
	input  logic         rstN,
	input  axiReq_t      req,
	output axiRsp_t      rsp,
	output logic         launch,  // ctrl write accepted this cycle
	output arithCmd_t    cmd,
	input  arithResult_t result
);

	typedef enum logic {wrIdle, wrResp} wrState_e;
	typedef enum logic {rdIdle, rdResp} rdState_e;

	wrState_e             wrState;
	rdState_e             rdState;
	logic                 wrReady;   // awready and wready together
	logic                 rdReady;
	logic                 wrAccept;  // aw and w handshake
	logic                 rdAccept;
	logic                 wrOk;      // address is writable
	logic                 rdOk;      // address is mapped
	axiResp_e             bResp;
	axiResp_e             rResp;
	logic [dataWidth-1:0] rdMux;
	logic [dataWidth-1:0] rData;
	logic [opWidth-1:0]   aReg;
	logic [opWidth-1:0]   bReg;
	arithOp_e             opReg;

	assign wrAccept = wrReady & req.awvalid & req.wvalid;
	assign rdAccept = rdReady & req.arvalid;
	assign launch   = wrAccept & (req.awaddr == regCtrl);

	// regResult and unmapped holes refuse writes
	assign wrOk = (req.awaddr == regA) | (req.awaddr == regB) | (req.awaddr == regCtrl);

	// write channel fsm
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrState <= wrIdle;
			wrReady <= 1'b0;
			bResp   <= respOkay;
		end else begin
			wrReady <= 1'b0;  // ready is a single pulse
			case (wrState)
				wrIdle: begin
					if (wrAccept) begin
						wrState <= wrResp;
						bResp   <= wrOk ? respOkay : respSlvErr;
					end else if (req.awvalid && req.wvalid) begin
						wrReady <= 1'b1;  // both valids seen
					end
				end
				wrResp: if (req.bready) wrState <= wrIdle;
				default: wrState <= wrIdle;
			endcase
		end
	end

	// operand and opcode storage
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			aReg  <= '0;
			bReg  <= '0;
			opReg <= opAdd;
		end else if (wrAccept) begin
			case (req.awaddr)
				regA:    aReg  <= req.wdata[opWidth-1:0];
				regB:    bReg  <= req.wdata[opWidth-1:0];
				regCtrl: opReg <= arithOp_e'(req.wdata[$bits(arithOp_e)-1:0]);
				default: ;  // nothing stored
			endcase
		end
	end

	// new opcode goes straight through on launch
	assign cmd = '{
		a:  aReg,
		b:  bReg,
		op: launch ? arithOp_e'(req.wdata[$bits(arithOp_e)-1:0]) : opReg
	};

	// read mux
	always_comb begin
		rdMux = '0;
		rdOk  = 1'b1;
		case (req.araddr)
			regA:    rdMux[opWidth-1:0] = aReg;
			regB:    rdMux[opWidth-1:0] = bReg;
			regCtrl: rdMux[$bits(arithOp_e)-1:0] = opReg;  // last opcode
			regResult: begin
				rdMux[opWidth-1:0] = result.sum;
				rdMux[ovfBit]      = result.ovf;
				rdMux[doneBit]     = result.done;
			end
			default: rdOk = 1'b0;  // hole in the map
		endcase
	end

	// read channel fsm
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdState <= rdIdle;
			rdReady <= 1'b0;
			rResp   <= respOkay;
		end else begin
			rdReady <= 1'b0;
			case (rdState)
				rdIdle: begin
					if (rdAccept) begin
						rdState <= rdResp;
						rResp   <= rdOk ? respOkay : respSlvErr;
					end else if (req.arvalid) begin
						rdReady <= 1'b1;
					end
				end
				rdResp: if (req.rready) rdState <= rdIdle;
				default: rdState <= rdIdle;
			endcase
		end
	end

	// read data held until rready
	always_ff @(posedge clk) begin
		if (rdAccept)
			rData <= rdMux;
	end

	always_comb begin
		rsp.awready = wrReady;
		rsp.wready  = wrReady;
		rsp.bvalid  = (wrState == wrResp);
		rsp.bresp   = bResp;
		rsp.arready = rdReady;
		rsp.rdata   = rData;
		rsp.rvalid  = (rdState == rdResp);
		rsp.rresp   = rResp;
	end

endmodule

`default_nettype wire

/* prefixAndOr.sv */
`timescale 1ns/1ps
`default_nettype none

// prefix generate/propagate: GO[i],PO[i] cover bits i..0
module prefixAndOr
	import arithPkg::*;
#(
	parameter int width = opWidth,      // word width
	parameter int speed = prefixSpeed   // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] GI,  // per-bit generate
	input  logic [width-1:0] PI,  // per-bit propagate
	output logic [width-1:0] GO,  // prefix generate
	output logic [width-1:0] PO   // prefix propagate
);

	localparam int depth = $clog2(width);  // levels of one log tree

	if (speed == 2) begin : sklansky
		// row l holds groups aligned to 2**l
		logic [depth:0][width-1:0] gT, pT;

		assign gT[0] = GI;
		assign pT[0] = PI;

		for (genvar l = 1; l <= depth; l++) begin : level
			for (genvar i = 0; i < width; i++) begin : node
				if ((i / 2**(l-1)) % 2 == 1) begin : black
					// upper half of a group takes the top of the lower half
					localparam int j = i - i % 2**(l-1) - 1;
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][j]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][j];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];  // pass through
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end

		assign GO = gT[depth];
		assign PO = pT[depth];

	end else if (speed == 1) begin : brentKung
		// up-sweep rows 1..depth, down-sweep rows depth+1..2*depth-1
		logic [2*depth-1:0][width-1:0] gT, pT;

		assign gT[0] = GI;
		assign pT[0] = PI;

		// up-sweep builds the power-of-two spans
		for (genvar l = 1; l <= depth; l++) begin : upLevel
			for (genvar i = 0; i < width; i++) begin : node
				if ((i + 1) % 2**l == 0) begin : black
					localparam int j = i - 2**(l-1);  // top of left sibling
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][j]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][j];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end

		// down-sweep fills the bits in between
		for (genvar l = depth + 1; l < 2 * depth; l++) begin : downLevel
			localparam int d = 2 * depth - l;  // span shrinks each row
			for (genvar i = 0; i < width; i++) begin : node
				if (i >= 2**d && (i + 1) % 2**d == 2**(d-1)) begin : black
					localparam int j = i - 2**(d-1);  // already a full prefix
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][j]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][j];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end

		assign GO = gT[2*depth-1];
		assign PO = pT[2*depth-1];

	end else begin : serial
		// plain ripple chain, smallest and slowest
		logic [width-1:0] gT, pT;

		assign gT[0] = GI[0];
		assign pT[0] = PI[0];

		for (genvar i = 1; i < width; i++) begin : node
			assign gT[i] = GI[i] | (PI[i] & gT[i-1]);
			assign pT[i] = PI[i] & pT[i-1];
		end

		assign GO = gT;
		assign PO = pT;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
	--top-module arithUnitTb -o arithUnitSim &&
./obj_dir/arithUnitSim | tee /dev/stderr | grep -qx "test passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

/* vlog.f */
axiLitePkg.sv
arithPkg.sv
prefixAndOr.sv
addSubV.sv
arithExec.sv
axiLiteRegs.sv
arithUnitTop.sv
arithUnit_assertions.sv
arithUnitTb.sv
